// ==== src/soc_pkg.sv ====
// ------------------------------------------------------------
// System control slice shared definitions
// ------------------------------------------------------------
package soc_pkg;

	// Bus widths
	localparam int WB_ADR_W = 32;
	localparam int DATA_W = 32;
	localparam int CSR_ADR_W = 14;
	// Bank select on top, register select below
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = 10;

	typedef logic [CSR_ADR_W-1:0] csr_addr_t;
	typedef logic [DATA_W-1:0] csr_data_t;

	// ------------------------------------------------------------
	// CSR address map
	// ------------------------------------------------------------
	localparam logic [CSR_BANK_W-1:0] CSR_BANK_SYSCTL = 4'd1;

	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IRQEN = 10'd2;
	localparam logic [CSR_REG_W-1:0] REG_TIMER0_BASE = 10'd4;
	localparam logic [CSR_REG_W-1:0] REG_TIMER1_BASE = 10'd8;
	localparam logic [CSR_REG_W-1:0] REG_SYSTEM_ID = 10'd30;
	localparam logic [CSR_REG_W-1:0] REG_HARD_RESET = 10'd31;

	// Timer registers, relative to the timer base
	localparam logic [CSR_REG_W-1:0] TMR_CTRL = 10'd0;
	localparam logic [CSR_REG_W-1:0] TMR_COMPARE = 10'd1;
	localparam logic [CSR_REG_W-1:0] TMR_COUNTER = 10'd2;
	localparam int TMR_EN_BIT = 0;
	localparam int TMR_AR_BIT = 1;

	// ASCII "MONE"
	localparam csr_data_t SYSTEM_ID = 32'h4D4F4E45;

	localparam int GPIO_IN_W = 3;
	localparam int GPIO_OUT_W = 2;

	// Read-data slots, one per CSR slave
	localparam int NUM_CSR_SLAVES = 3;
	localparam int SLOT_SYSCTL = 0;
	localparam int SLOT_TIMER0 = 1;
	localparam int SLOT_TIMER1 = 2;

	// Interrupt vector
	localparam int IRQ_W = 3;
	localparam int IRQ_GPIO = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_TIMER1 = 2;
	typedef logic [IRQ_W-1:0] irq_vec_t;

	// Reset sequencing counts
	localparam int RST_CNT_W = 8;
	localparam logic [RST_CNT_W-1:0] RST_HOLD_CYCLES = 8'd200;
	localparam logic [RST_CNT_W-1:0] FLASH_RST_CYCLES = 8'd128;

endpackage

// ==== src/csr_bus_if.sv ====
// ------------------------------------------------------------
// CSR bus
// ------------------------------------------------------------
interface csr_bus_if
	import soc_pkg::*;
();

	// Driven by the bridge
	csr_addr_t csr_a;
	logic csr_we;
	csr_data_t csr_dw;

	// One read-data entry per slave, zero when not selected
	csr_data_t csr_dr [NUM_CSR_SLAVES];

	// Bridge side
	modport master (
		output csr_a,
		output csr_we,
		output csr_dw,
		input csr_dr
	);

	// Peripheral side, each slave drives its own entry
	modport slave (
		input csr_a,
		input csr_we,
		input csr_dw,
		output csr_dr
	);

endinterface

// ==== src/reset_seq.sv ====
// ------------------------------------------------------------
// Reset sequencer
// ------------------------------------------------------------
module reset_seq
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic trigger_reset,
	input logic hard_reset_req_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	// External button or software request
	logic reset_src;
	logic [RST_CNT_W-1:0] hold_cnt;
	logic [RST_CNT_W-1:0] flash_cnt;

	assign reset_src = trigger_reset | hard_reset_req_i;

	// ------------------------------------------------------------
	// System reset hold
	// ------------------------------------------------------------
	// Reload on any source, then count down to zero
	always_ff @(posedge sys_clk) begin
		if (reset_src) begin
			hold_cnt <= RST_HOLD_CYCLES;
			sys_rst_o <= 1'b1;
		end else begin
			if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			// Drops one edge after the counter reaches zero
			sys_rst_o <= (hold_cnt != '0);
		end
	end

	assign periph_rst_n_o = ~sys_rst_o;

	// ------------------------------------------------------------
	// Boot flash reset
	// ------------------------------------------------------------
	// Shorter count, so the flash is ready before the system runs
	always_ff @(posedge sys_clk) begin
		if (reset_src) begin
			flash_cnt <= '0;
		end else if (flash_cnt != FLASH_RST_CYCLES) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	// Saturates at the release count
	assign flash_rst_n_o = (flash_cnt == FLASH_RST_CYCLES);

endmodule

// ==== src/csr_bridge.sv ====
// ------------------------------------------------------------
// Wishbone to CSR bridge
// ------------------------------------------------------------
module csr_bridge
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	input logic [WB_ADR_W-1:0] wb_adr_i,
	input csr_data_t wb_dat_i,
	output csr_data_t wb_dat_o,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	output logic wb_ack_o,
	csr_bus_if.master csr
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_CAPTURE,
		ST_ACK_DLY
	} state_t;

	state_t state;
	csr_data_t rd_or;
	logic start;

	// New cycle, but not in the idle cycle after an ack
	assign start = wb_cyc_i & wb_stb_i & ~wb_ack_o;

	// ------------------------------------------------------------
	// Read data combining
	// ------------------------------------------------------------
	// Unselected slaves return zero, so a plain OR is enough
	always_comb begin
		rd_or = '0;
		for (int i = 0; i < NUM_CSR_SLAVES; i++) begin
			rd_or = rd_or | csr.csr_dr[i];
		end
	end

	// ------------------------------------------------------------
	// Access sequencing
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
			csr.csr_a <= '0;
		end else begin
			// Write strobe and ack are single-cycle pulses
			csr.csr_we <= 1'b0;
			wb_ack_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						// Word address from byte address
						csr.csr_a <= wb_adr_i[CSR_ADR_W+1:2];
						csr.csr_we <= wb_we_i;
						state <= ST_ACCESS;
					end
				end
				// Slaves register read data on this edge
				ST_ACCESS: state <= ST_CAPTURE;
				ST_CAPTURE: state <= ST_ACK_DLY;
				ST_ACK_DLY: begin
					wb_ack_o <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Write data follows the accepted cycle
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && start) begin
			csr.csr_dw <= wb_dat_i;
		end
	end

	// Held through the ack cycle
	always_ff @(posedge sys_clk) begin
		if (state == ST_CAPTURE) begin
			wb_dat_o <= rd_or;
		end
	end

endmodule

// ==== src/sysctl_regs.sv ====
// ------------------------------------------------------------
// System controller registers
// ------------------------------------------------------------
module sysctl_regs
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	csr_bus_if.slave csr,
	input logic [GPIO_IN_W-1:0] gpio_i,
	output logic [GPIO_OUT_W-1:0] gpio_o,
	output logic gpio_irq_o,
	output logic hard_reset_req_o
);

	logic bank_sel;
	logic [CSR_REG_W-1:0] reg_sel;
	logic wr_en;

	// Input synchronizer and previous value
	logic [GPIO_IN_W-1:0] gpio_meta;
	logic [GPIO_IN_W-1:0] gpio_sync;
	logic [GPIO_IN_W-1:0] gpio_prev;

	logic [GPIO_IN_W-1:0] irq_en;
	csr_data_t rd_val;
	csr_data_t rd_q;

	// Bank decode
	assign bank_sel = (csr.csr_a[CSR_ADR_W-1:CSR_REG_W] == CSR_BANK_SYSCTL);
	assign reg_sel = csr.csr_a[CSR_REG_W-1:0];
	assign wr_en = bank_sel & csr.csr_we;

	// ------------------------------------------------------------
	// GPIO inputs
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
		gpio_prev <= gpio_sync;
	end

	// Pulse on any change of an enabled input
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_irq_o <= 1'b0;
		end else begin
			gpio_irq_o <= |((gpio_sync ^ gpio_prev) & irq_en);
		end
	end

	// ------------------------------------------------------------
	// Writable registers
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_o <= '0;
			irq_en <= '0;
			hard_reset_req_o <= 1'b0;
		end else begin
			hard_reset_req_o <= 1'b0;
			if (wr_en) begin
				case (reg_sel)
					REG_GPIO_OUT: gpio_o <= csr.csr_dw[GPIO_OUT_W-1:0];
					REG_GPIO_IRQEN: irq_en <= csr.csr_dw[GPIO_IN_W-1:0];
					// Data is ignored, any write restarts the reset sequence
					REG_HARD_RESET: hard_reset_req_o <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------
	always_comb begin
		rd_val = '0;
		case (reg_sel)
			REG_GPIO_IN: rd_val = {{(DATA_W-GPIO_IN_W){1'b0}}, gpio_sync};
			REG_GPIO_OUT: rd_val = {{(DATA_W-GPIO_OUT_W){1'b0}}, gpio_o};
			REG_GPIO_IRQEN: rd_val = {{(DATA_W-GPIO_IN_W){1'b0}}, irq_en};
			REG_SYSTEM_ID: rd_val = SYSTEM_ID;
			default: rd_val = '0;
		endcase
	end

	// Registered, zero outside our bank
	always_ff @(posedge sys_clk) begin
		rd_q <= bank_sel ? rd_val : '0;
	end

	assign csr.csr_dr[SLOT_SYSCTL] = rd_q;

endmodule

// ==== src/sysctl_timer.sv ====
// ------------------------------------------------------------
// Interval timer
// ------------------------------------------------------------
module sysctl_timer
	import soc_pkg::*;
#(
	parameter logic [CSR_REG_W-1:0] REG_BASE = REG_TIMER0_BASE,
	parameter int SLOT = SLOT_TIMER0
) (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_bus_if.slave csr,
	output logic irq_o
);

	// Absolute register offsets in the bank
	localparam logic [CSR_REG_W-1:0] ADR_CTRL = REG_BASE + TMR_CTRL;
	localparam logic [CSR_REG_W-1:0] ADR_COMPARE = REG_BASE + TMR_COMPARE;
	localparam logic [CSR_REG_W-1:0] ADR_COUNTER = REG_BASE + TMR_COUNTER;

	logic bank_sel;
	logic [CSR_REG_W-1:0] reg_sel;
	logic wr_en;
	logic en;
	logic autorestart;
	csr_data_t compare;
	csr_data_t counter;
	logic match;
	csr_data_t rd_q;

	assign bank_sel = (csr.csr_a[CSR_ADR_W-1:CSR_REG_W] == CSR_BANK_SYSCTL);
	assign reg_sel = csr.csr_a[CSR_REG_W-1:0];
	assign wr_en = bank_sel & csr.csr_we;

	assign match = en & (counter == compare);

	// ------------------------------------------------------------
	// Counter and control
	// ------------------------------------------------------------
	// CSR writes win over counting
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en <= 1'b0;
			autorestart <= 1'b0;
			compare <= '0;
			counter <= '0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= match;
			if (wr_en && reg_sel == ADR_CTRL) begin
				en <= csr.csr_dw[TMR_EN_BIT];
				autorestart <= csr.csr_dw[TMR_AR_BIT];
			end else if (match && !autorestart) begin
				// One-shot stops itself
				en <= 1'b0;
			end
			if (wr_en && reg_sel == ADR_COMPARE) begin
				compare <= csr.csr_dw;
			end
			if (wr_en && reg_sel == ADR_COUNTER) begin
				counter <= csr.csr_dw;
			end else if (match) begin
				counter <= '0;
			end else if (en) begin
				counter <= counter + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		rd_q <= '0;
		if (bank_sel) begin
			case (reg_sel)
				ADR_CTRL: rd_q <= {{(DATA_W-2){1'b0}}, autorestart, en};
				ADR_COMPARE: rd_q <= compare;
				ADR_COUNTER: rd_q <= counter;
				default: rd_q <= '0;
			endcase
		end
	end

	assign csr.csr_dr[SLOT] = rd_q;

endmodule

// ==== src/soc_ctrl_top.sv ====
// ------------------------------------------------------------
// System control top level
// ------------------------------------------------------------
module soc_ctrl_top
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic trigger_reset,

	// Wishbone slave
	input logic [WB_ADR_W-1:0] wb_adr_i,
	input csr_data_t wb_dat_i,
	output csr_data_t wb_dat_o,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	output logic wb_ack_o,

	// GPIO and interrupts
	input logic [GPIO_IN_W-1:0] gpio_i,
	output logic [GPIO_OUT_W-1:0] gpio_o,
	output irq_vec_t irq_o,

	// Reset outputs
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	logic hard_reset_req;
	logic gpio_irq;
	logic timer0_irq;
	logic timer1_irq;

	csr_bus_if csr_bus ();

	// ------------------------------------------------------------
	// Reset and bus
	// ------------------------------------------------------------
	reset_seq reset_seq_i (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_req_i(hard_reset_req),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	csr_bridge csr_bridge_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_ack_o(wb_ack_o),
		.csr(csr_bus.master)
	);

	// ------------------------------------------------------------
	// CSR peripherals
	// ------------------------------------------------------------
	sysctl_regs sysctl_regs_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.slave),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.gpio_irq_o(gpio_irq),
		.hard_reset_req_o(hard_reset_req)
	);

	sysctl_timer #(
		.REG_BASE(REG_TIMER0_BASE),
		.SLOT(SLOT_TIMER0)
	) timer0_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.slave),
		.irq_o(timer0_irq)
	);

	sysctl_timer #(
		.REG_BASE(REG_TIMER1_BASE),
		.SLOT(SLOT_TIMER1)
	) timer1_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.slave),
		.irq_o(timer1_irq)
	);

	// Interrupt vector
	assign irq_o[IRQ_GPIO] = gpio_irq;
	assign irq_o[IRQ_TIMER0] = timer0_irq;
	assign irq_o[IRQ_TIMER1] = timer1_irq;

endmodule

// ==== verif/soc_ctrl_sva.sv ====
// ------------------------------------------------------------
// Bridge handshake assertions
// ------------------------------------------------------------
module soc_ctrl_sva (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic wb_ack_i,
	input logic csr_we_i
);

	// Assertion failure count
	int fail_count = 0;

	// Single-cycle acknowledge
	ack_one_cycle: assert property (@(posedge sys_clk) wb_ack_i |=> !wb_ack_i)
	else begin
		$error("wb_ack_o held for more than one cycle");
		fail_count++;
	end

	// Ack only for a live cycle
	ack_in_cycle: assert property (@(posedge sys_clk) $rose(wb_ack_i) |-> (wb_cyc_i && wb_stb_i))
	else begin
		$error("wb_ack_o rose without cyc and stb");
		fail_count++;
	end

	ack_quiet_in_reset: assert property (@(posedge sys_clk) sys_rst_i |-> !wb_ack_i)
	else begin
		$error("wb_ack_o high during sys_rst");
		fail_count++;
	end

	// CSR write strobe follows a sampled write request
	we_after_request: assert property (@(posedge sys_clk)
		$rose(csr_we_i) |-> $past(wb_cyc_i && wb_stb_i && wb_we_i))
	else begin
		$error("csr_we rose without a sampled write request");
		fail_count++;
	end

endmodule

bind csr_bridge soc_ctrl_sva bridge_sva_i (
	.sys_clk(sys_clk),
	.sys_rst_i(sys_rst_i),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_we_i(wb_we_i),
	.wb_ack_i(wb_ack_o),
	.csr_we_i(csr.csr_we)
);

// ==== verif/soc_ctrl_tb.sv ====
// ------------------------------------------------------------
// System control slice testbench
// ------------------------------------------------------------
module soc_ctrl_tb
	import soc_pkg::*;
();

	// Ack edge counted from the first edge after the request is driven
	localparam int ACK_EDGE = 4;
	localparam int TMR0_N = 20;
	localparam int TMR1_N = 10;
	localparam int GPIO_WATCH = 8;
	localparam int TMR0_WATCH = 40;
	localparam int TMR1_WATCH = 60;
	// Run length: two reset sequences, bus accesses, interrupt windows
	localparam int RESET_RUN = 8 + int'(RST_HOLD_CYCLES) + 4;
	localparam int BUS_RUN = 30 * 8;
	localparam int WATCH_RUN = 3 * GPIO_WATCH + TMR0_WATCH + TMR1_WATCH;
	localparam int TIMEOUT_CYCLES = (2 * RESET_RUN + BUS_RUN + WATCH_RUN) * 3 / 2;
	// ASCII text of the ID register
	localparam csr_data_t ID_EXP = "MONE";
	localparam csr_data_t GPIO_OUT_MASK = (32'd1 << GPIO_OUT_W) - 32'd1;
	localparam csr_data_t TMR_EN = 32'd1 << TMR_EN_BIT;
	localparam csr_data_t TMR_AR = 32'd1 << TMR_AR_BIT;

	logic sys_clk;
	logic trigger_reset;
	logic [WB_ADR_W-1:0] wb_adr;
	csr_data_t wb_dat_w;
	csr_data_t wb_dat_r;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_ack;
	logic [GPIO_IN_W-1:0] gpio_in;
	logic [GPIO_OUT_W-1:0] gpio_out;
	irq_vec_t irq;
	logic flash_rst_n;
	logic periph_rst_n;
	csr_data_t gpio_out_word;

	integer seed;
	int mismatch_count = 0;
	int other_count = 0;
	int sva_count = 0;
	int cycle_count = 0;
	// Edges at which the watched interrupt bit was high
	int pulse_edges[$];

	soc_ctrl_top soc_ctrl_top_i (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_ack_o(wb_ack),
		.gpio_i(gpio_in),
		.gpio_o(gpio_out),
		.irq_o(irq),
		.flash_rst_n_o(flash_rst_n),
		.periph_rst_n_o(periph_rst_n)
	);

	assign gpio_out_word = {{(DATA_W-GPIO_OUT_W){1'b0}}, gpio_out};

	initial sys_clk = 1'b0;
	always #5 sys_clk = ~sys_clk;

	// Run limit
	always @(posedge sys_clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_irq(input string name, input irq_vec_t got, input irq_vec_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			mismatch_count++;
		end
	endtask

	// Edge counts and pulse counts
	task automatic expect_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			mismatch_count++;
		end
	endtask

	// ------------------------------------------------------------
	// Wishbone master
	// ------------------------------------------------------------
	// Bank on top of the word address, word address from bit 2
	function automatic logic [WB_ADR_W-1:0] csr_byte_addr(input logic [CSR_REG_W-1:0] reg_off);
		return {{(WB_ADR_W-CSR_ADR_W-2){1'b0}}, CSR_BANK_SYSCTL, reg_off, 2'b00};
	endfunction

	task automatic bus_idle();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
	endtask

	task automatic wb_access(input logic we, input logic [CSR_REG_W-1:0] reg_off,
		input csr_data_t wdata, output csr_data_t rdata);
		int edges;
		edges = 0;
		rdata = '0;
		@(posedge sys_clk);
		#1;
		wb_adr = csr_byte_addr(reg_off);
		wb_dat_w = wdata;
		wb_we = we;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		// Held until ack, bounded wait
		do begin
			@(posedge sys_clk);
			edges++;
			@(negedge sys_clk);
		end while (!wb_ack && edges < 16);
		if (!wb_ack) begin
			$display("ERROR no acknowledge for register %0d after %0d cycles", reg_off, edges);
			other_count++;
		end else begin
			expect_count("wb_ack_o edge", edges, ACK_EDGE);
			rdata = wb_dat_r;
		end
		@(posedge sys_clk);
		#1;
		bus_idle();
		// Ack is a one-cycle pulse
		@(negedge sys_clk);
		check_bit("wb_ack_o", wb_ack, 1'b0);
	endtask

	task automatic wb_write(input logic [CSR_REG_W-1:0] reg_off, input csr_data_t wdata);
		csr_data_t discard;
		wb_access(1'b1, reg_off, wdata, discard);
	endtask

	task automatic wb_read(input logic [CSR_REG_W-1:0] reg_off, output csr_data_t rdata);
		wb_access(1'b0, reg_off, '0, rdata);
	endtask

	// ------------------------------------------------------------
	// Observation helpers
	// ------------------------------------------------------------
	task automatic watch_irq(input int idx, input int cycles);
		int k;
		pulse_edges.delete();
		for (k = 1; k <= cycles; k++) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			if (irq[idx]) begin
				pulse_edges.push_back(k);
			end
		end
	endtask

	// Edge 1 is the first edge without a reset source
	task automatic measure_release();
		int k;
		int flash_edge;
		int periph_edge;
		flash_edge = 0;
		periph_edge = 0;
		for (k = 1; k <= int'(RST_HOLD_CYCLES) + 4; k++) begin
			@(posedge sys_clk);
			#1;
			if (k == 1) begin
				bus_idle();
			end
			@(negedge sys_clk);
			if (flash_rst_n && flash_edge == 0) begin
				flash_edge = k;
			end
			if (periph_rst_n && periph_edge == 0) begin
				periph_edge = k;
			end
			// Everything quiet while the system is in reset
			if (!periph_rst_n) begin
				check_data("gpio_o", gpio_out_word, '0);
				check_irq("irq_o", irq, '0);
				check_bit("wb_ack_o", wb_ack, 1'b0);
			end
		end
		expect_count("flash_rst_n_o release edge", flash_edge, int'(FLASH_RST_CYCLES));
		expect_count("periph_rst_n_o release edge", periph_edge, int'(RST_HOLD_CYCLES) + 1);
	endtask

	// Bridge goes into reset before it can ack this write
	task automatic hard_reset_request();
		int k;
		logic seen;
		seen = 1'b0;
		@(posedge sys_clk);
		#1;
		wb_adr = csr_byte_addr(REG_HARD_RESET);
		wb_dat_w = $random(seed);
		wb_we = 1'b1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		for (k = 0; k < 8 && !seen; k++) begin
			@(negedge sys_clk);
			seen = !periph_rst_n;
		end
		if (!seen) begin
			$display("ERROR periph_rst_n_o did not fall after the hard reset write");
			other_count++;
		end
		check_bit("flash_rst_n_o", flash_rst_n, 1'b0);
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic reset_sequence();
		repeat (8) @(posedge sys_clk);
		#1;
		trigger_reset = 1'b0;
		measure_release();
	endtask

	task automatic bus_and_registers();
		csr_data_t rdata;
		csr_data_t wdata;
		wb_read(REG_SYSTEM_ID, rdata);
		check_data("SYSTEM_ID", rdata, ID_EXP);
		wdata = $random(seed);
		wb_write(REG_GPIO_OUT, wdata);
		check_data("gpio_o", gpio_out_word, wdata & GPIO_OUT_MASK);
		wb_read(REG_GPIO_OUT, rdata);
		check_data("GPIO_OUT readback", rdata, wdata & GPIO_OUT_MASK);
		// Hole between the mask and timer 0
		wb_read(REG_GPIO_IRQEN + 10'd1, rdata);
		check_data("unmapped register", rdata, '0);
	endtask

	task automatic gpio_inputs();
		csr_data_t rdata;
		@(posedge sys_clk);
		#1;
		gpio_in = 3'b101;
		wb_read(REG_GPIO_IN, rdata);
		check_data("GPIO_IN", rdata, {{(DATA_W-GPIO_IN_W){1'b0}}, 3'b101});
		// Mask bit 1 only
		wb_write(REG_GPIO_IRQEN, 32'h2);
		@(posedge sys_clk);
		#1;
		gpio_in = 3'b111;
		watch_irq(IRQ_GPIO, GPIO_WATCH);
		expect_count("masked gpio irq pulses", pulse_edges.size(), 1);
		if (pulse_edges.size() > 0 && pulse_edges[0] > 4) begin
			$display("ERROR gpio interrupt came %0d cycles after the change", pulse_edges[0]);
			other_count++;
		end
		// Bit 2 is not in the mask
		@(posedge sys_clk);
		#1;
		gpio_in = 3'b011;
		watch_irq(IRQ_GPIO, GPIO_WATCH);
		expect_count("unmasked gpio irq pulses", pulse_edges.size(), 0);
		check_irq("irq_o", irq, '0);
	endtask

	task automatic timer_modes();
		csr_data_t rdata;
		int i;
		// One-shot
		wb_write(REG_TIMER0_BASE + TMR_COMPARE, csr_data_t'(TMR0_N));
		wb_write(REG_TIMER0_BASE + TMR_CTRL, TMR_EN);
		watch_irq(IRQ_TIMER0, TMR0_WATCH);
		expect_count("timer 0 irq pulses", pulse_edges.size(), 1);
		wb_read(REG_TIMER0_BASE + TMR_CTRL, rdata);
		check_data("timer 0 TMR_CTRL", rdata, '0);
		wb_read(REG_TIMER0_BASE + TMR_COUNTER, rdata);
		check_data("timer 0 TMR_COUNTER", rdata, '0);
		// Autorestart, period of compare plus one
		wb_write(REG_TIMER1_BASE + TMR_COMPARE, csr_data_t'(TMR1_N));
		wb_write(REG_TIMER1_BASE + TMR_CTRL, TMR_EN | TMR_AR);
		watch_irq(IRQ_TIMER1, TMR1_WATCH);
		if (pulse_edges.size() < 3) begin
			$display("ERROR timer 1 gave only %0d interrupts", pulse_edges.size());
			other_count++;
		end
		for (i = 1; i < pulse_edges.size(); i++) begin
			expect_count("timer 1 irq period", pulse_edges[i] - pulse_edges[i-1], TMR1_N + 1);
		end
		wb_write(REG_TIMER1_BASE + TMR_CTRL, '0);
	endtask

	task automatic hard_reset_sequence();
		csr_data_t rdata;
		wb_write(REG_GPIO_OUT, GPIO_OUT_MASK);
		check_data("gpio_o", gpio_out_word, GPIO_OUT_MASK);
		hard_reset_request();
		measure_release();
		wb_read(REG_GPIO_OUT, rdata);
		check_data("GPIO_OUT after hard reset", rdata, '0);
		check_data("gpio_o", gpio_out_word, '0);
	endtask

	// ------------------------------------------------------------
	// Sequence
	// ------------------------------------------------------------
	initial begin
		seed = 44715;
		trigger_reset = 1'b1;
		gpio_in = '0;
		bus_idle();
		reset_sequence();
		bus_and_registers();
		gpio_inputs();
		timer_modes();
		hard_reset_sequence();
		sva_count = soc_ctrl_top_i.csr_bridge_i.bridge_sva_i.fail_count;
		$display("Mismatches %0d, other errors %0d, assertion failures %0d",
			mismatch_count, other_count, sva_count);
		if (mismatch_count + other_count + sva_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
src/soc_pkg.sv
src/csr_bus_if.sv
src/reset_seq.sv
src/csr_bridge.sv
src/sysctl_regs.sv
src/sysctl_timer.sv
src/soc_ctrl_top.sv
verif/soc_ctrl_sva.sv
verif/soc_ctrl_tb.sv

// ==== Makefile ====
# Verilator build of the system control slice testbench
TOP := soc_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)

# Pass only when the pass line appears in the output
run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
